//--- bp_predictor.f
+incdir+hw
hw/bp_pkg.sv
hw/bp_ubtb.sv
hw/bp_btb.sv
hw/bp_bimodal.sv
hw/bp_ras.sv
hw/bp_s2_override.sv
hw/bp_predictor.sv
dv/tb_bp_predictor.sv

//--- dv/bp_golden.txt
# U start valid s0_valid s0_off s0_target tail_valid tail_off tail_type tail_target taken
# S flush_pc ras_ptr / R max_stall_cycles (decimal) / E start target taken redirect
# cold start with empty tables.
E 80000000 80000020 0 0
E 80000020 80000040 0 0
R 5
E 80000040 80000060 0 0
# direct tail jump found by the micro-BTB.
U 80000100 1 0 00 0000 1 1c 2 00400 2
S 80000100 0
E 80000100 80000500 1 0
E 80000500 80000520 0 0
# blocks 0x200 and 0x400 share a micro-BTB set, so the BTB corrects 0x200.
U 80000200 1 0 00 0000 1 1c 2 00800 2
U 80000400 1 0 00 0000 1 1c 2 00200 2
S 80000200 0
E 80000200 80000220 0 0
E 80000200 80000a00 1 1
E 80000a00 80000a20 0 0
# slot 0 conditional trained taken twice, then not taken twice.
U 80001040 1 1 08 0100 0 00 0 00000 1
U 80001040 1 1 08 0100 0 00 0 00000 1
S 80001040 0
E 80001040 80001140 1 0
E 80001140 80001160 0 0
U 80001040 1 1 08 0100 0 00 0 00000 0
U 80001040 1 1 08 0100 0 00 0 00000 0
S 80001040 0
E 80001040 80001060 0 0
E 80001060 80001080 0 0
# call in the tail of 0x2060, return block at 0x3080.
U 80002060 1 0 00 0000 1 1c 4 01020 2
U 80003080 1 0 00 0000 1 04 5 00000 2
S 80002060 0
E 80002060 80003080 1 0
E 80003080 800030a0 0 0
E 80003080 80002080 1 1
E 80002080 800020a0 0 0
# a second call pushes above pointer 1 and the squash puts pointer 1 back.
U 80005000 1 0 00 0000 1 1c 4 fe080 2
S 80005000 1
E 80005000 80003080 1 0
E 80003080 800030a0 0 0
S 80003080 1
E 80003080 800030a0 0 0
E 80003080 80002080 1 1
E 80002080 800020a0 0 0
# stalls before and after an override.
S 80000200 0
E 80000200 80000220 0 0
R 6
E 80000200 80000a00 1 1
R 4
E 80000a00 80000a20 0 0

//--- dv/tb_bp_predictor.sv
`timescale 1ns/1ps
`include "bp_params.svh"

module tb_bp_predictor;

    logic               clk;
    logic               arst_n_i;
    bp_pkg::bp_pred_t   pred_o;
    logic               valid_o;
    logic               redirect_o;
    logic               ready_i;
    logic               squash_valid_i;
    bp_pkg::bp_squash_t squash_i;
    logic               upd_valid_i;
    bp_pkg::bp_update_t upd_i;

    logic [31:0] fld [10];
    logic [31:0] rng_state;
    logic        timed_out;
    int          val_errs;
    int          other_errs;
    int          checks;
    int          line_no;

    bp_predictor i_dut (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .pred_o         (pred_o),
        .valid_o        (valid_o),
        .redirect_o     (redirect_o),
        .ready_i        (ready_i),
        .squash_valid_i (squash_valid_i),
        .squash_i       (squash_i),
        .upd_valid_i    (upd_valid_i),
        .upd_i          (upd_i)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic send_update();
        bp_pkg::bp_update_t u;
        u                           = '0;
        u.start                     = fld[0];
        u.entry.valid               = fld[1][0];
        u.entry.slot0_valid         = fld[2][0];
        u.entry.slot0_offset        = fld[3][`BP_BLOCK_OFF_BITS-1:0];
        u.entry.slot0_target        = fld[4][`BP_BR_OFF_BITS-1:0];
        u.entry.tail_valid          = fld[5][0];
        u.entry.tail_offset         = fld[6][`BP_BLOCK_OFF_BITS-1:0];
        u.entry.tail_type           = bp_pkg::br_type_e'(fld[7][2:0]);
        u.entry.tail_target.abs_low = fld[8][`BP_TAIL_BITS-1:0];
        u.taken                     = fld[9][`BP_SLOT_NUM-1:0];
        @(posedge clk);
        ready_i        <= 1'b0;
        squash_valid_i <= 1'b0;
        upd_valid_i    <= 1'b1;
        upd_i          <= u;
    endtask

    task automatic send_squash();
        bp_pkg::bp_squash_t s;
        s.flush_pc = fld[0];
        s.ras_ptr  = fld[1][`BP_RAS_PTR_BITS-1:0];
        @(posedge clk);
        ready_i        <= 1'b0;
        upd_valid_i    <= 1'b0;
        squash_valid_i <= 1'b1;
        squash_i       <= s;
    endtask

    // the output seen in the first stalled cycle must hold for the whole stall.
    task automatic stall_ready(input int max_len);
        int               len;
        bp_pkg::bp_pred_t held;
        rng_state = xorshift32(rng_state);
        len       = 1 + int'(rng_state % max_len);
        @(posedge clk);
        ready_i        <= 1'b0;
        upd_valid_i    <= 1'b0;
        squash_valid_i <= 1'b0;
        @(negedge clk);
        held = pred_o;
        for (int i = 1; i < len; i++) begin
            @(negedge clk);
            if (pred_o !== held) begin
                $display("ERR pred_o line %0d: expected %h, got %h", line_no, held, pred_o);
                val_errs++;
            end
        end
    endtask

    task automatic check_pred();
        int waited;
        @(posedge clk);
        ready_i        <= 1'b1;
        upd_valid_i    <= 1'b0;
        squash_valid_i <= 1'b0;
        @(negedge clk);
        waited = 0;
        while (valid_o !== 1'b1 && waited < 64) begin
            @(negedge clk);
            waited++;
        end
        if (valid_o !== 1'b1) begin
            $display("timeout: no valid prediction in 64 cycles for golden line %0d", line_no);
            other_errs++;
            timed_out = 1'b1;
        end else begin
            checks++;
            if (pred_o.start !== fld[0]) begin
                $display("ERR pred_o.start line %0d: expected %h, got %h",
                         line_no, fld[0], pred_o.start);
                val_errs++;
            end
            if (pred_o.target !== fld[1]) begin
                $display("ERR pred_o.target line %0d: expected %h, got %h",
                         line_no, fld[1], pred_o.target);
                val_errs++;
            end
            if (pred_o.taken !== fld[2][0]) begin
                $display("ERR pred_o.taken line %0d: expected %h, got %h",
                         line_no, fld[2][0], pred_o.taken);
                val_errs++;
            end
            if (redirect_o !== fld[3][0]) begin
                $display("ERR redirect_o line %0d: expected %h, got %h",
                         line_no, fld[3][0], redirect_o);
                val_errs++;
            end
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    need;
        int    stall_max;
        byte   cmd;
        string line;
        string body;
        clk            = 1'b0;
        arst_n_i       = 1'b0;
        ready_i        = 1'b0;
        squash_valid_i = 1'b0;
        squash_i       = '0;
        upd_valid_i    = 1'b0;
        upd_i          = '0;
        rng_state      = 32'd31222;
        timed_out      = 1'b0;
        val_errs       = 0;
        other_errs     = 0;
        checks         = 0;
        line_no        = 0;
        repeat (16) @(posedge clk);
        arst_n_i <= 1'b1;

        fd = $fopen("dv/bp_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/bp_golden.txt");
            other_errs++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                line_no++;
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                cmd  = line.getc(0);
                body = line.substr(2, line.len() - 1);
                n    = 0;
                need = 1;
                case (cmd)
                    "U": begin
                        need = 10;
                        n = $sscanf(body, "%h %h %h %h %h %h %h %h %h %h", fld[0], fld[1],
                                    fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8],
                                    fld[9]);
                        if (n == need) send_update();
                    end
                    "S": begin
                        need = 2;
                        n = $sscanf(body, "%h %h", fld[0], fld[1]);
                        if (n == need) send_squash();
                    end
                    "R": begin
                        n = $sscanf(body, "%d", stall_max);
                        if (n == 1 && stall_max > 0) stall_ready(stall_max);
                    end
                    "E": begin
                        need = 4;
                        n = $sscanf(body, "%h %h %h %h", fld[0], fld[1], fld[2], fld[3]);
                        if (n == need) check_pred();
                    end
                    default: n = -1;
                endcase
                if (n != need || (cmd == "R" && stall_max <= 0)) begin
                    $display("golden line %0d could not be parsed", line_no);
                    other_errs++;
                end
            end
            $fclose(fd);
        end

        @(posedge clk);
        ready_i        <= 1'b0;
        upd_valid_i    <= 1'b0;
        squash_valid_i <= 1'b0;
        if (checks == 0) begin
            $display("no prediction was checked");
            other_errs++;
        end
        $display("checks %0d, value errors %0d, other errors %0d", checks, val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- hw/bp_bimodal.sv
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_bimodal (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [`BP_VADDR_BITS-1:0] lookup_pc_i,
    input  logic                      advance_i,
    output logic [`BP_SLOT_NUM-1:0]   taken_o,
    input  logic                      upd_valid_i,
    input  bp_pkg::bp_update_t        upd_i
);
    localparam int IDX_W = $clog2(`BP_BTB_ENTRIES);

    logic [`BP_SLOT_NUM-1:0][1:0] ctr_q [`BP_BTB_ENTRIES];
    logic [IDX_W-1:0]             rd_idx;
    logic [IDX_W-1:0]             wr_idx;
    logic [`BP_SLOT_NUM-1:0]      slot_vld;

    assign rd_idx   = lookup_pc_i[`BP_BLOCK_OFF_BITS +: IDX_W];
    assign wr_idx   = upd_i.start[`BP_BLOCK_OFF_BITS +: IDX_W];
    assign slot_vld = {upd_i.entry.valid && upd_i.entry.tail_valid,
                       upd_i.entry.valid && upd_i.entry.slot0_valid};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
                ctr_q[i] <= {`BP_SLOT_NUM{2'b01}};
            end
            taken_o <= '0;
        end else begin
            if (upd_valid_i) begin
                for (int s = 0; s < `BP_SLOT_NUM; s++) begin
                    if (slot_vld[s]) begin
                        ctr_q[wr_idx][s] <= bp_pkg::ctr_next(ctr_q[wr_idx][s], upd_i.taken[s]);
                    end
                end
            end
            if (advance_i) begin
                for (int s = 0; s < `BP_SLOT_NUM; s++) begin
                    taken_o[s] <= ctr_q[rd_idx][s][1];
                end
            end
        end
    end

endmodule

//--- hw/bp_btb.sv
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_btb (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [`BP_VADDR_BITS-1:0] lookup_pc_i,
    input  logic                      advance_i,
    output bp_pkg::btb_entry_t        entry_o,
    input  logic                      upd_valid_i,
    input  bp_pkg::bp_update_t        upd_i
);
    localparam int IDX_W = $clog2(`BP_BTB_ENTRIES);

    logic [`BP_BTB_ENTRIES-1:0] vld_q;
    bp_pkg::btb_entry_t         mem_q [`BP_BTB_ENTRIES];
    bp_pkg::btb_entry_t         rd_q;
    logic                       rd_vld_q;

    logic [IDX_W-1:0]           rd_idx;
    logic [IDX_W-1:0]           wr_idx;
    bp_pkg::btb_entry_t         wr_ent;

    assign rd_idx = lookup_pc_i[`BP_BLOCK_OFF_BITS +: IDX_W];
    assign wr_idx = upd_i.start[`BP_BLOCK_OFF_BITS +: IDX_W];

    // the stored tag always comes from the block address being trained.
    always_comb begin
        wr_ent     = upd_i.entry;
        wr_ent.tag = upd_i.start[`BP_VADDR_BITS-1 -: `BP_BTB_TAG_BITS];
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q    <= '0;
            rd_vld_q <= 1'b0;
        end else begin
            if (upd_valid_i) begin
                vld_q[wr_idx] <= upd_i.entry.valid;
            end
            if (advance_i) begin
                rd_vld_q <= vld_q[rd_idx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid_i) begin
            mem_q[wr_idx] <= wr_ent;
        end
        if (advance_i) begin
            rd_q <= mem_q[rd_idx];
        end
    end

    always_comb begin
        entry_o       = rd_q;
        entry_o.valid = rd_vld_q;
    end

endmodule

//--- hw/bp_params.svh
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

`define BP_VADDR_BITS     32
`define BP_BLOCK_BYTES    32
`define BP_BLOCK_OFF_BITS 5
`define BP_SIZE_BITS      6

`define BP_UBTB_ENTRIES   16
`define BP_UBTB_TAG_BITS  8
`define BP_BTB_ENTRIES    64
`define BP_BTB_TAG_BITS   21

`define BP_RAS_DEPTH      8
`define BP_RAS_PTR_BITS   3

// slot 0 holds conditional branches only, slot 1 is the tail slot.
`define BP_SLOT_NUM       2
`define BP_BR_OFF_BITS    13
`define BP_TAIL_BITS      20

`define BP_RESET_PC       32'h8000_0000

`endif

//--- hw/bp_pkg.sv
`include "bp_params.svh"

package bp_pkg;

    typedef enum logic [2:0] {
        BR_NONE     = 3'd0,
        BR_COND     = 3'd1,
        BR_DIRECT   = 3'd2,
        BR_INDIRECT = 3'd3,
        BR_CALL     = 3'd4,
        BR_RET      = 3'd5
    } br_type_e;

    // indirect tails keep the low target bits, the others a start-relative offset.
    typedef union packed {
        logic signed [`BP_TAIL_BITS-1:0] rel_off;
        logic        [`BP_TAIL_BITS-1:0] abs_low;
    } tail_target_u;

    typedef struct packed {
        logic                                valid;
        logic [`BP_BTB_TAG_BITS-1:0]         tag;
        logic                                slot0_valid;
        logic [`BP_BLOCK_OFF_BITS-1:0]       slot0_offset;
        logic signed [`BP_BR_OFF_BITS-1:0]   slot0_target;
        logic                                tail_valid;
        logic [`BP_BLOCK_OFF_BITS-1:0]       tail_offset;
        br_type_e                            tail_type;
        tail_target_u                        tail_target;
    } btb_entry_t;

    typedef struct packed {
        logic [`BP_VADDR_BITS-1:0]   start;
        logic [`BP_VADDR_BITS-1:0]   target;
        logic                        taken;
        br_type_e                    br_type;
        logic [`BP_SIZE_BITS-1:0]    size;
        logic [`BP_RAS_PTR_BITS-1:0] ras_ptr;
    } bp_pred_t;

    typedef struct packed {
        logic [`BP_VADDR_BITS-1:0]   flush_pc;
        logic [`BP_RAS_PTR_BITS-1:0] ras_ptr;
    } bp_squash_t;

    typedef struct packed {
        logic [`BP_VADDR_BITS-1:0] start;
        btb_entry_t                entry;
        logic [`BP_SLOT_NUM-1:0]   taken;
    } bp_update_t;

    function automatic logic [1:0] ctr_next(input logic [1:0] ctr, input logic taken);
        if (taken) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'b01;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'b01;
    endfunction

    function automatic logic [`BP_SIZE_BITS-1:0] slot_size(
        input logic [`BP_BLOCK_OFF_BITS-1:0] offset
    );
        return {1'b0, offset} + 3'd4;
    endfunction

    function automatic logic [`BP_VADDR_BITS-1:0] slot0_target(
        input logic [`BP_VADDR_BITS-1:0] start,
        input btb_entry_t                e
    );
        return start + {{(`BP_VADDR_BITS-`BP_BR_OFF_BITS){e.slot0_target[`BP_BR_OFF_BITS-1]}},
                        e.slot0_target};
    endfunction

    function automatic logic [`BP_VADDR_BITS-1:0] tail_target(
        input logic [`BP_VADDR_BITS-1:0] start,
        input btb_entry_t                e
    );
        if (e.tail_type == BR_INDIRECT) begin
            return {start[`BP_VADDR_BITS-1:`BP_TAIL_BITS], e.tail_target.abs_low};
        end
        return start + {{(`BP_VADDR_BITS-`BP_TAIL_BITS){e.tail_target.rel_off[`BP_TAIL_BITS-1]}},
                        e.tail_target.rel_off};
    endfunction

    function automatic bp_pred_t fall_pred(input logic [`BP_VADDR_BITS-1:0] start);
        bp_pred_t p;
        p         = '0;
        p.start   = start;
        p.target  = start + `BP_BLOCK_BYTES;
        p.br_type = BR_NONE;
        p.size    = `BP_SIZE_BITS'(`BP_BLOCK_BYTES);
        return p;
    endfunction

endpackage

//--- hw/bp_predictor.sv
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_predictor (
    input  logic               clk,
    input  logic               arst_n_i,
    output bp_pkg::bp_pred_t   pred_o,
    output logic               valid_o,
    output logic               redirect_o,
    input  logic               ready_i,
    input  logic               squash_valid_i,
    input  bp_pkg::bp_squash_t squash_i,
    input  logic               upd_valid_i,
    input  bp_pkg::bp_update_t upd_i
);
    logic [`BP_VADDR_BITS-1:0]   pc_q;
    bp_pkg::bp_pred_t            ubtb_pred;
    bp_pkg::bp_pred_t            s1_pred;
    bp_pkg::bp_pred_t            s2_q;
    logic                        s2_vld_q;
    bp_pkg::bp_pred_t            s2_pred;
    logic                        override;
    bp_pkg::btb_entry_t          btb_entry;
    logic [`BP_SLOT_NUM-1:0]     cond_taken;
    logic [`BP_VADDR_BITS-1:0]   ras_top;
    logic [`BP_RAS_PTR_BITS-1:0] ras_ptr;
    logic                        fire;
    logic                        s2_fire;
    logic                        ras_push;
    logic                        ras_pop;

    // a prediction is always on offer, the fetch queue decides when it moves.
    assign valid_o    = 1'b1;
    assign fire       = valid_o && ready_i;
    assign redirect_o = override;
    assign pred_o     = override ? s2_pred : s1_pred;

    always_comb begin
        s1_pred         = ubtb_pred;
        s1_pred.ras_ptr = ras_ptr;
    end

    bp_ubtb i_ubtb (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .lookup_pc_i (pc_q),
        .pred_o      (ubtb_pred),
        .upd_valid_i (upd_valid_i),
        .upd_i       (upd_i)
    );

    bp_btb i_btb (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .lookup_pc_i (pc_q),
        .advance_i   (fire),
        .entry_o     (btb_entry),
        .upd_valid_i (upd_valid_i),
        .upd_i       (upd_i)
    );

    bp_bimodal i_bimodal (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .lookup_pc_i (pc_q),
        .advance_i   (fire),
        .taken_o     (cond_taken),
        .upd_valid_i (upd_valid_i),
        .upd_i       (upd_i)
    );

    bp_s2_override i_s2_override (
        .s2_i         (s2_q),
        .s2_valid_i   (s2_vld_q),
        .entry_i      (btb_entry),
        .cond_taken_i (cond_taken),
        .ras_top_i    (ras_top),
        .ras_ptr_i    (ras_ptr),
        .pred_o       (s2_pred),
        .override_o   (override)
    );

    // the RAS follows the stage-two view of a block once that block is accepted.
    assign s2_fire  = fire && s2_vld_q && !squash_valid_i;
    assign ras_push = s2_fire && s2_pred.taken && s2_pred.br_type == bp_pkg::BR_CALL;
    assign ras_pop  = s2_fire && s2_pred.taken && s2_pred.br_type == bp_pkg::BR_RET;

    bp_ras i_ras (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .push_i        (ras_push),
        .pop_i         (ras_pop),
        .push_addr_i   (s2_pred.start + s2_pred.size),
        .restore_i     (squash_valid_i),
        .restore_ptr_i (squash_i.ras_ptr),
        .top_o         (ras_top),
        .ptr_o         (ras_ptr)
    );

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q     <= `BP_RESET_PC;
            s2_vld_q <= 1'b0;
        end else if (squash_valid_i) begin
            pc_q     <= squash_i.flush_pc;
            s2_vld_q <= 1'b0;
        end else if (fire) begin
            pc_q     <= pred_o.target;
            // an overridden block was already judged, so stage two stays empty.
            s2_vld_q <= !override;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && !squash_valid_i && !override) begin
            s2_q <= s1_pred;
        end
    end

    a_pred_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_o && !ready_i && !squash_valid_i && !upd_valid_i |=> $stable(pred_o));

endmodule

//--- hw/bp_ras.sv
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_ras (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        push_i,
    input  logic                        pop_i,
    input  logic [`BP_VADDR_BITS-1:0]   push_addr_i,
    input  logic                        restore_i,
    input  logic [`BP_RAS_PTR_BITS-1:0] restore_ptr_i,
    output logic [`BP_VADDR_BITS-1:0]   top_o,
    output logic [`BP_RAS_PTR_BITS-1:0] ptr_o
);
    logic [`BP_VADDR_BITS-1:0]   stack_q [`BP_RAS_DEPTH];
    logic [`BP_RAS_PTR_BITS-1:0] ptr_q;
    logic [`BP_RAS_PTR_BITS-1:0] ptr_inc;
    logic [`BP_RAS_PTR_BITS-1:0] ptr_dec;

    // the depth is a power of two, so the pointer wraps on its own.
    assign ptr_inc = ptr_q + 1'b1;
    assign ptr_dec = ptr_q - 1'b1;
    assign top_o   = stack_q[ptr_q];
    assign ptr_o   = ptr_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q <= '0;
        end else if (restore_i) begin
            ptr_q <= restore_ptr_i;
        end else if (push_i) begin
            ptr_q <= ptr_inc;
        end else if (pop_i) begin
            ptr_q <= ptr_dec;
        end
    end

    // old entries are overwritten, never cleared, so a restore can reuse them.
    always_ff @(posedge clk) begin
        if (push_i && !restore_i) begin
            stack_q[ptr_inc] <= push_addr_i;
        end
    end

    a_no_push_and_pop: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(push_i && pop_i));

endmodule

//--- hw/bp_s2_override.sv
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_s2_override (
    input  bp_pkg::bp_pred_t            s2_i,
    input  logic                        s2_valid_i,
    input  bp_pkg::btb_entry_t          entry_i,
    input  logic [`BP_SLOT_NUM-1:0]     cond_taken_i,
    input  logic [`BP_VADDR_BITS-1:0]   ras_top_i,
    input  logic [`BP_RAS_PTR_BITS-1:0] ras_ptr_i,
    output bp_pkg::bp_pred_t            pred_o,
    output logic                        override_o
);
    logic hit;
    logic slot0_taken;
    logic tail_taken;

    assign hit = entry_i.valid &&
                 (entry_i.tag == s2_i.start[`BP_VADDR_BITS-1 -: `BP_BTB_TAG_BITS]);

    assign slot0_taken = entry_i.slot0_valid && cond_taken_i[0];

    // calls, returns and jumps are always taken; a conditional tail follows its counter.
    assign tail_taken = entry_i.tail_valid && entry_i.tail_type != bp_pkg::BR_NONE &&
                        (entry_i.tail_type != bp_pkg::BR_COND || cond_taken_i[1]);

    always_comb begin
        pred_o = s2_i;
        if (hit) begin
            if (slot0_taken) begin
                pred_o.target  = bp_pkg::slot0_target(s2_i.start, entry_i);
                pred_o.taken   = 1'b1;
                pred_o.br_type = bp_pkg::BR_COND;
                pred_o.size    = bp_pkg::slot_size(entry_i.slot0_offset);
            end else if (tail_taken) begin
                if (entry_i.tail_type == bp_pkg::BR_RET) begin
                    pred_o.target = ras_top_i;
                end else begin
                    pred_o.target = bp_pkg::tail_target(s2_i.start, entry_i);
                end
                pred_o.taken   = 1'b1;
                pred_o.br_type = entry_i.tail_type;
                pred_o.size    = bp_pkg::slot_size(entry_i.tail_offset);
            end else begin
                pred_o = bp_pkg::fall_pred(s2_i.start);
            end
        end
        pred_o.ras_ptr = ras_ptr_i;
    end

    // only the target decides an override, a matching target keeps stage one.
    assign override_o = s2_valid_i && hit && (pred_o.target != s2_i.target);

endmodule

//--- hw/bp_ubtb.sv
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_ubtb (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [`BP_VADDR_BITS-1:0] lookup_pc_i,
    output bp_pkg::bp_pred_t          pred_o,
    input  logic                      upd_valid_i,
    input  bp_pkg::bp_update_t        upd_i
);
    localparam int IDX_W = $clog2(`BP_UBTB_ENTRIES);

    logic [`BP_UBTB_ENTRIES-1:0]  vld_q;
    logic [`BP_UBTB_TAG_BITS-1:0] tag_q  [`BP_UBTB_ENTRIES];
    bp_pkg::btb_entry_t           ent_q  [`BP_UBTB_ENTRIES];
    logic [1:0]                   hint_q [`BP_UBTB_ENTRIES];

    logic [IDX_W-1:0]             rd_idx;
    logic [IDX_W-1:0]             wr_idx;
    logic [`BP_UBTB_TAG_BITS-1:0] rd_tag;
    logic [`BP_UBTB_TAG_BITS-1:0] wr_tag;
    bp_pkg::btb_entry_t           rd_ent;
    logic                         hit;
    logic                         wr_same;

    assign rd_idx  = lookup_pc_i[`BP_BLOCK_OFF_BITS +: IDX_W];
    assign rd_tag  = lookup_pc_i[`BP_BLOCK_OFF_BITS+IDX_W +: `BP_UBTB_TAG_BITS];
    assign wr_idx  = upd_i.start[`BP_BLOCK_OFF_BITS +: IDX_W];
    assign wr_tag  = upd_i.start[`BP_BLOCK_OFF_BITS+IDX_W +: `BP_UBTB_TAG_BITS];
    assign rd_ent  = ent_q[rd_idx];
    assign hit     = vld_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign wr_same = vld_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

    always_comb begin
        pred_o = bp_pkg::fall_pred(lookup_pc_i);
        // the earlier slot wins when both would be taken.
        if (hit && rd_ent.slot0_valid && hint_q[rd_idx][1]) begin
            pred_o.target  = bp_pkg::slot0_target(lookup_pc_i, rd_ent);
            pred_o.taken   = 1'b1;
            pred_o.br_type = bp_pkg::BR_COND;
            pred_o.size    = bp_pkg::slot_size(rd_ent.slot0_offset);
        end else if (hit && rd_ent.tail_valid && rd_ent.tail_type != bp_pkg::BR_RET &&
                     rd_ent.tail_type != bp_pkg::BR_NONE) begin
            pred_o.target  = bp_pkg::tail_target(lookup_pc_i, rd_ent);
            pred_o.taken   = 1'b1;
            pred_o.br_type = rd_ent.tail_type;
            pred_o.size    = bp_pkg::slot_size(rd_ent.tail_offset);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= '0;
        end else if (upd_valid_i) begin
            vld_q[wr_idx] <= upd_i.entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid_i) begin
            tag_q[wr_idx] <= wr_tag;
            ent_q[wr_idx] <= upd_i.entry;
            // a newly allocated block starts weak in the resolved direction.
            if (wr_same) begin
                hint_q[wr_idx] <= bp_pkg::ctr_next(hint_q[wr_idx], upd_i.taken[0]);
            end else begin
                hint_q[wr_idx] <= upd_i.taken[0] ? 2'b10 : 2'b01;
            end
        end
    end

    a_upd_slots_need_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        upd_valid_i && !upd_i.entry.valid |-> !upd_i.entry.slot0_valid && !upd_i.entry.tail_valid);

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the predictor testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

mkdir -p build
if [ $? -ne 0 ]; then
    echo "cannot create the build directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_bp_predictor -f bp_predictor.f \
    --Mdir build -o tb_bp_predictor
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./build/tb_bp_predictor > build/sim.log 2>&1
run_status=$?
cat build/sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation passed" build/sim.log; then
    exit 0
fi
exit 1
